/* Bender.yml */
package:
  name: thr_accel

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/thr_accel_pkg.sv
      - rtl/thr_cfg_if.sv
      - rtl/thr_stream_if.sv
      - rtl/thr_accel_fifo.sv
      - rtl/thr_accel_regs.sv
      - rtl/thr_accel_engine.sv
      - rtl/thr_accel_result.sv
      - rtl/thr_accel_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/thr_accel_assert.sv
      - testbench/tb_thr_accel.sv

/* rtl/thr_accel_engine.sv */
/* Read side of a job. Issues word reads from the source address while there
   is room for the answers, and pushes each returning word into the FIFO. */
`timescale 1ns/1ps
`include "thr_accel_macros.svh"

module thr_accel_engine (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  thr_cfg_if.engine            cfg,
  thr_stream_if.engine         strm,
  output logic                 rd_req_o,
  output thr_accel_pkg::addr_t rd_addr_o,
  input  logic                 rd_gnt_i,
  input  logic                 rd_rvalid_i,
  input  thr_accel_pkg::word_t rd_rdata_i
);

  localparam int unsigned OUT_W = $clog2(`THR_FIFO_DEPTH) + 1;
  // Stored plus outstanding words stay below this before a new request
  localparam logic [OUT_W-1:0] FILL_LIMIT = OUT_W'(`THR_FIFO_DEPTH - 1);

  thr_accel_pkg::rd_state_e rd_state_q;
  thr_accel_pkg::rd_state_e rd_state_d;
  thr_accel_pkg::addr_t     rd_ptr_q;
  thr_accel_pkg::size_t     cnt_q;
  logic [OUT_W-1:0]         out_q;
  logic [OUT_W-1:0]         fill;
  logic                     room;
  logic                     rd_fire;
  logic                     fifo_flush;
  logic                     fifo_full;
  thr_accel_pkg::usage_t    fifo_usage;

  assign rd_addr_o = rd_ptr_q;
  assign rd_fire   = rd_req_o && rd_gnt_i;

  // Back-pressure, counting answers still on their way
  assign fill = {1'b0, fifo_usage} + out_q;
  assign room = !fifo_full && (fill < FILL_LIMIT);

  assign strm.rd_busy = (rd_state_q == thr_accel_pkg::RD_ON) || (out_q != '0);

  always_comb begin
    rd_state_d = rd_state_q;
    rd_req_o   = 1'b0;
    fifo_flush = 1'b0;
    unique case (rd_state_q)
      thr_accel_pkg::RD_IDLE: begin
        if (cfg.start) begin
          fifo_flush = 1'b1;
          rd_state_d = thr_accel_pkg::RD_ON;
        end
      end
      thr_accel_pkg::RD_ON: begin
        if (cnt_q == '0) begin
          rd_state_d = thr_accel_pkg::RD_IDLE;
        end else begin
          rd_req_o = room;
        end
      end
      default: rd_state_d = thr_accel_pkg::RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_state_q <= thr_accel_pkg::RD_IDLE;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
      out_q      <= '0;
    end else begin
      rd_state_q <= rd_state_d;
      if (cfg.start) begin
        rd_ptr_q <= cfg.src_addr;
        cnt_q    <= cfg.size;
      end else if (rd_fire) begin
        rd_ptr_q <= rd_ptr_q + 32'd4;
        cnt_q    <= cnt_q - 1'b1;
      end
      // Grants in, answers out
      out_q <= out_q + OUT_W'(rd_fire) - OUT_W'(rd_rvalid_i);
    end
  end

  thr_accel_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (fifo_flush),
    .push_i  (rd_rvalid_i),
    .data_i  (rd_rdata_i),
    .pop_i   (strm.pop),
    .data_o  (strm.data),
    .full_o  (fifo_full),
    .empty_o (strm.empty),
    .usage_o (fifo_usage)
  );

endmodule

/* rtl/thr_accel_fifo.sv */
/* Small synchronous word FIFO between the read and write masters.
   Flush empties it in one cycle; usage wraps to zero when full. */
`timescale 1ns/1ps
`include "thr_accel_macros.svh"

module thr_accel_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  thr_accel_pkg::word_t  data_i,
  input  logic                  pop_i,
  output thr_accel_pkg::word_t  data_o,
  output logic                  full_o,
  output logic                  empty_o,
  output thr_accel_pkg::usage_t usage_o
);

  localparam int unsigned DEPTH = `THR_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  thr_accel_pkg::word_t mem_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [PTR_W:0]       count_q;
  logic                 do_push;
  logic                 do_pop;

  assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
  assign empty_o = (count_q == '0);
  assign usage_o = count_q[PTR_W-1:0];
  assign data_o  = mem_q[rd_ptr_q];

  // Overflow and underflow requests are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (do_pop)  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      count_q <= count_q + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
  end

endmodule

/* rtl/thr_accel_macros.svh */
/* Register map, word width and FIFO depth of the threshold accelerator.
   Included by the package and by every RTL file that needs these values. */
`ifndef THR_ACCEL_MACROS_SVH
`define THR_ACCEL_MACROS_SVH

`define THR_DATA_W      32
`define THR_SIZE_W      10
`define THR_FIFO_DEPTH  4

// Byte offsets on the register port
`define THR_REG_SRC     8'h00
`define THR_REG_DST     8'h04
`define THR_REG_THR     8'h08
`define THR_REG_READY   8'h0C
`define THR_REG_SIZE    8'h10
`define THR_REG_START   8'h14
`define THR_REG_CLIP    8'h18

`endif

/* rtl/thr_accel_pkg.sv */
/* Shared types of the threshold accelerator.
   Blocks refer to them by scoped names. */
`include "thr_accel_macros.svh"

package thr_accel_pkg;

  // Data word on both memory channels and the register port
  typedef logic [`THR_DATA_W-1:0] word_t;

  // Byte address
  typedef logic [31:0] addr_t;

  // Word count of a job, also the width of the clipped count
  typedef logic [`THR_SIZE_W-1:0] size_t;

  // FIFO occupancy, wraps to zero when full
  typedef logic [$clog2(`THR_FIFO_DEPTH)-1:0] usage_t;

  // Top job sequencing
  typedef enum logic [1:0] {
    READY,
    STARTING,
    RUNNING
  } job_state_e;

  // Read master
  typedef enum logic {
    RD_IDLE,
    RD_ON
  } rd_state_e;

  // Write master
  typedef enum logic {
    WR_IDLE,
    WR_ON
  } wr_state_e;

endpackage

/* rtl/thr_accel_regs.sv */
/* Register decoder and job sequencer. Holds the programmed registers,
   turns a start write into a single start pulse and tracks the job state. */
`timescale 1ns/1ps
`include "thr_accel_macros.svh"

module thr_accel_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 reg_valid_i,
  input  logic                 reg_write_i,
  input  logic [7:0]           reg_addr_i,
  input  thr_accel_pkg::word_t reg_wdata_i,
  output thr_accel_pkg::word_t reg_rdata_o,
  thr_cfg_if.regs              cfg
);

  thr_accel_pkg::addr_t      src_q;
  thr_accel_pkg::addr_t      dst_q;
  thr_accel_pkg::word_t      thr_q;
  thr_accel_pkg::size_t      size_q;
  logic                      ready_q;
  logic                      start_q;
  logic                      start_pending_q;
  logic                      reg_wr;
  thr_accel_pkg::job_state_e state_q;
  thr_accel_pkg::job_state_e state_d;

  assign reg_wr = reg_valid_i && reg_write_i;

  assign cfg.src_addr  = src_q;
  assign cfg.dst_addr  = dst_q;
  assign cfg.threshold = thr_q;
  assign cfg.size      = size_q;
  assign cfg.start     = (state_q == thr_accel_pkg::STARTING);

  // Read data is returned in the access cycle
  always_comb begin
    reg_rdata_o = '0;
    if (reg_valid_i) begin
      case (reg_addr_i)
        `THR_REG_SRC:   reg_rdata_o = src_q;
        `THR_REG_DST:   reg_rdata_o = dst_q;
        `THR_REG_THR:   reg_rdata_o = thr_q;
        `THR_REG_READY: reg_rdata_o = {{(`THR_DATA_W-1){1'b0}}, ready_q};
        `THR_REG_SIZE:  reg_rdata_o = {{(`THR_DATA_W-`THR_SIZE_W){1'b0}}, size_q};
        `THR_REG_START: reg_rdata_o = {{(`THR_DATA_W-1){1'b0}}, start_q};
        `THR_REG_CLIP:  reg_rdata_o = {{(`THR_DATA_W-`THR_SIZE_W){1'b0}}, cfg.clip_cnt};
        default:        reg_rdata_o = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q   <= '0;
      dst_q   <= '0;
      thr_q   <= '0;
      size_q  <= '0;
      ready_q <= 1'b0;
      start_q <= 1'b0;
    end else begin
      if (reg_wr) begin
        case (reg_addr_i)
          `THR_REG_SRC:   src_q   <= reg_wdata_i;
          `THR_REG_DST:   dst_q   <= reg_wdata_i;
          `THR_REG_THR:   thr_q   <= reg_wdata_i;
          `THR_REG_SIZE:  size_q  <= reg_wdata_i[`THR_SIZE_W-1:0];
          `THR_REG_START: start_q <= reg_wdata_i[0];
          default: ;
        endcase
      end else begin
        // Start is a strobe, cleared by any idle register cycle
        start_q <= 1'b0;
      end
      // Done wins over a software write of ready
      if (cfg.done) begin
        ready_q <= 1'b1;
      end else if (reg_wr && reg_addr_i == `THR_REG_READY) begin
        ready_q <= reg_wdata_i[0];
      end else if (cfg.start) begin
        ready_q <= 1'b0;
      end
    end
  end

  // Zero-size starts never become pending
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_pending_q <= 1'b0;
    end else if (cfg.start) begin
      start_pending_q <= 1'b0;
    end else if (start_q && size_q != '0) begin
      start_pending_q <= 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      thr_accel_pkg::READY:    if (start_pending_q) state_d = thr_accel_pkg::STARTING;
      thr_accel_pkg::STARTING: state_d = thr_accel_pkg::RUNNING;
      thr_accel_pkg::RUNNING:  if (cfg.done) state_d = thr_accel_pkg::READY;
      default:                 state_d = thr_accel_pkg::READY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= thr_accel_pkg::READY;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* rtl/thr_accel_result.sv */
/* Write side of a job. Clips each FIFO word against the threshold, writes it
   to the destination and signals done once nothing is left in flight. */
`timescale 1ns/1ps

module thr_accel_result (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  thr_cfg_if.result            cfg,
  thr_stream_if.result         strm,
  output logic                 wr_req_o,
  output thr_accel_pkg::addr_t wr_addr_o,
  output thr_accel_pkg::word_t wr_wdata_o,
  input  logic                 wr_gnt_i
);

  thr_accel_pkg::wr_state_e wr_state_q;
  thr_accel_pkg::wr_state_e wr_state_d;
  thr_accel_pkg::addr_t     wr_ptr_q;
  thr_accel_pkg::size_t     clip_q;
  logic                     below;
  logic                     wr_fire;
  logic                     done;

  // Unsigned compare, words under the threshold go out as zero
  assign below      = (strm.data < cfg.threshold);
  assign wr_wdata_o = below ? '0 : strm.data;
  assign wr_addr_o  = wr_ptr_q;
  assign wr_fire    = wr_req_o && wr_gnt_i;

  assign strm.pop     = wr_fire;
  assign cfg.done     = done;
  assign cfg.clip_cnt = clip_q;

  always_comb begin
    wr_state_d = wr_state_q;
    wr_req_o   = 1'b0;
    done       = 1'b0;
    unique case (wr_state_q)
      thr_accel_pkg::WR_IDLE: begin
        if (cfg.start) wr_state_d = thr_accel_pkg::WR_ON;
      end
      thr_accel_pkg::WR_ON: begin
        if (strm.empty && !strm.rd_busy) begin
          // Last word written and no read left outstanding
          done       = 1'b1;
          wr_state_d = thr_accel_pkg::WR_IDLE;
        end else begin
          wr_req_o = !strm.empty;
        end
      end
      default: wr_state_d = thr_accel_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state_q <= thr_accel_pkg::WR_IDLE;
      wr_ptr_q   <= '0;
      clip_q     <= '0;
    end else begin
      wr_state_q <= wr_state_d;
      if (cfg.start) begin
        wr_ptr_q <= cfg.dst_addr;
        clip_q   <= '0;
      end else if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 32'd4;
        if (below) clip_q <= clip_q + 1'b1;
      end
    end
  end

endmodule

/* rtl/thr_accel_top.sv */
/* Top of the threshold accelerator. Register port plus one memory read
   and one memory write channel, all as plain ports. */
`timescale 1ns/1ps

module thr_accel_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Register port
  input  logic                 reg_valid_i,
  input  logic                 reg_write_i,
  input  logic [7:0]           reg_addr_i,
  input  thr_accel_pkg::word_t reg_wdata_i,
  output thr_accel_pkg::word_t reg_rdata_o,
  // Memory read channel
  output logic                 rd_req_o,
  output thr_accel_pkg::addr_t rd_addr_o,
  input  logic                 rd_gnt_i,
  input  logic                 rd_rvalid_i,
  input  thr_accel_pkg::word_t rd_rdata_i,
  // Memory write channel
  output logic                 wr_req_o,
  output thr_accel_pkg::addr_t wr_addr_o,
  output thr_accel_pkg::word_t wr_wdata_o,
  input  logic                 wr_gnt_i
);

  thr_cfg_if    cfg_if ();
  thr_stream_if strm_if ();

  thr_accel_regs u_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .cfg         (cfg_if.regs)
  );

  thr_accel_engine u_engine (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg         (cfg_if.engine),
    .strm        (strm_if.engine),
    .rd_req_o    (rd_req_o),
    .rd_addr_o   (rd_addr_o),
    .rd_gnt_i    (rd_gnt_i),
    .rd_rvalid_i (rd_rvalid_i),
    .rd_rdata_i  (rd_rdata_i)
  );

  thr_accel_result u_result (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg        (cfg_if.result),
    .strm       (strm_if.result),
    .wr_req_o   (wr_req_o),
    .wr_addr_o  (wr_addr_o),
    .wr_wdata_o (wr_wdata_o),
    .wr_gnt_i   (wr_gnt_i)
  );

endmodule

/* rtl/thr_cfg_if.sv */
/* Job configuration from the register block to the execute and result blocks,
   with the done pulse and clipped count going back. */
`timescale 1ns/1ps

interface thr_cfg_if;

  thr_accel_pkg::addr_t src_addr;
  thr_accel_pkg::addr_t dst_addr;
  thr_accel_pkg::word_t threshold;
  thr_accel_pkg::size_t size;
  logic                 start;
  logic                 done;
  thr_accel_pkg::size_t clip_cnt;

  modport regs (
    output src_addr, dst_addr, threshold, size, start,
    input  done, clip_cnt
  );

  modport engine (input start, src_addr, size);

  modport result (
    input  start, dst_addr, threshold,
    output done, clip_cnt
  );

endinterface

/* rtl/thr_stream_if.sv */
/* FIFO head and read status from the execute block to the result block,
   with the pop strobe going back. */
`timescale 1ns/1ps

interface thr_stream_if;

  thr_accel_pkg::word_t data;
  logic                 empty;
  logic                 rd_busy;
  logic                 pop;

  modport engine (
    output data, empty, rd_busy,
    input  pop
  );

  modport result (
    input  data, empty, rd_busy,
    output pop
  );

endinterface

/* testbench/tb_clock_gen.sv */
/* Clock and reset source for the testbench.
   Free-running 20 ns clock, active-low reset released after 10 cycles. */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* testbench/tb_thr_accel.sv */
/* Testbench of the threshold accelerator. A word memory with random grant
   stalls serves both channels; tasks program the registers and check jobs. */
`timescale 1ns/1ps
`include "thr_accel_macros.svh"

module tb_thr_accel;

  logic                 clk;
  logic                 rst_n;
  logic                 reg_valid = 1'b0;
  logic                 reg_write = 1'b0;
  logic [7:0]           reg_addr  = '0;
  thr_accel_pkg::word_t reg_wdata = '0;
  thr_accel_pkg::word_t reg_rdata;
  logic                 rd_req;
  thr_accel_pkg::addr_t rd_addr;
  logic                 rd_gnt    = 1'b0;
  logic                 rd_rvalid = 1'b0;
  thr_accel_pkg::word_t rd_rdata  = '0;
  logic                 wr_req;
  thr_accel_pkg::addr_t wr_addr;
  thr_accel_pkg::word_t wr_wdata;
  logic                 wr_gnt    = 1'b0;

  thr_accel_pkg::word_t mem [1024];
  thr_accel_pkg::word_t rsp_data [$];
  int                   rsp_due [$];
  int                   cyc         = 0;
  int                   last_due    = 0;
  int                   due;
  integer               seed        = 32'hb0635d84;
  // Grant chance in quarters
  int                   grant_level = 3;
  int                   errors      = 0;
  int                   checks      = 0;
  int                   ncases      = 0;

  tb_clock_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  thr_accel_top dut (
    .clk_i (clk), .rst_ni (rst_n),
    .reg_valid_i (reg_valid), .reg_write_i (reg_write), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_rdata_o (reg_rdata),
    .rd_req_o (rd_req), .rd_addr_o (rd_addr), .rd_gnt_i (rd_gnt),
    .rd_rvalid_i (rd_rvalid), .rd_rdata_i (rd_rdata),
    .wr_req_o (wr_req), .wr_addr_o (wr_addr), .wr_wdata_o (wr_wdata), .wr_gnt_i (wr_gnt)
  );

  bind thr_accel_top thr_accel_assert u_assert (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .reg_valid_i (reg_valid_i), .reg_write_i (reg_write_i),
    .reg_addr_i (reg_addr_i), .reg_wdata_i (reg_wdata_i),
    .rd_req_i (rd_req_o), .rd_addr_i (rd_addr_o), .rd_gnt_i (rd_gnt_i),
    .rd_rvalid_i (rd_rvalid_i),
    .wr_req_i (wr_req_o), .wr_addr_i (wr_addr_o), .wr_wdata_i (wr_wdata_o),
    .wr_gnt_i (wr_gnt_i)
  );

  // Memory model answering in order one or two cycles after each read grant
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_gnt    <= 1'b0;
      wr_gnt    <= 1'b0;
      rd_rvalid <= 1'b0;
      rsp_data.delete();
      rsp_due.delete();
    end else begin
      cyc = cyc + 1;
      if (rd_req && rd_gnt) begin
        due = cyc + ($random(seed) & 1);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        rsp_data.push_back(mem[rd_addr[11:2]]);
        rsp_due.push_back(due);
      end
      if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin
        rd_rvalid <= 1'b1;
        rd_rdata  <= rsp_data.pop_front();
        void'(rsp_due.pop_front());
      end else begin
        rd_rvalid <= 1'b0;
      end
      if (wr_req && wr_gnt) mem[wr_addr[11:2]] = wr_wdata;
      rd_gnt <= (($random(seed) & 3) < grant_level);
      wr_gnt <= (($random(seed) & 3) < grant_level);
    end
  end

  task automatic write_reg(input logic [7:0] addr, input thr_accel_pkg::word_t data);
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_write <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_valid <= 1'b0;
    reg_write <= 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output thr_accel_pkg::word_t data);
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_write <= 1'b0;
    reg_addr  <= addr;
    @(negedge clk);
    data = reg_rdata;
    @(posedge clk);
    reg_valid <= 1'b0;
  endtask

  task automatic check_value(input string name, input thr_accel_pkg::word_t got,
                             input thr_accel_pkg::word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_ready(input int max_polls);
    thr_accel_pkg::word_t val;
    int                   n;
    val = '0;
    n   = 0;
    while (val[0] !== 1'b1 && n < max_polls) begin
      read_reg(`THR_REG_READY, val);
      n++;
    end
    if (val[0] !== 1'b1) begin
      $display("Timeout: ready stayed low for %0d register polls", max_polls);
      $display("test failed");
      $finish;
    end
  endtask

  // Start pulse comes 3 cycles after the start write and ready drops with it
  task automatic start_job(input thr_accel_pkg::addr_t src, input thr_accel_pkg::addr_t dst,
                           input thr_accel_pkg::word_t thr, input int size);
    thr_accel_pkg::word_t val;
    write_reg(`THR_REG_SRC, src);
    write_reg(`THR_REG_DST, dst);
    write_reg(`THR_REG_THR, thr);
    write_reg(`THR_REG_SIZE, 32'(size));
    write_reg(`THR_REG_START, 32'd1);
    repeat (4) @(posedge clk);
    read_reg(`THR_REG_READY, val);
    check_value("READY while busy", val, 32'd0);
  endtask

  task automatic check_job(input thr_accel_pkg::addr_t src, input thr_accel_pkg::addr_t dst,
                           input thr_accel_pkg::word_t thr, input int size,
                           input bit with_clip);
    thr_accel_pkg::word_t s;
    thr_accel_pkg::word_t exp;
    thr_accel_pkg::word_t val;
    int                   clipped;
    clipped = 0;
    for (int i = 0; i < size; i++) begin
      s   = mem[src[11:2] + i];
      exp = (s < thr) ? '0 : s;
      if (s < thr) clipped++;
      check_value($sformatf("mem[%h]", dst + 4 * i), mem[dst[11:2] + i], exp);
    end
    if (with_clip) begin
      read_reg(`THR_REG_CLIP, val);
      check_value("CLIP", val, 32'(clipped));
    end
  endtask

  task automatic fill_random(input thr_accel_pkg::addr_t base, input int n);
    @(negedge clk);
    for (int i = 0; i < n; i++) begin
      mem[base[11:2] + i] = $random(seed);
    end
  endtask

  task automatic report_case(input int num, input string name, input int mark);
    ncases++;
    $display("case %0d, %s: %0d mismatches", num, name, errors - mark);
  endtask

  initial begin
    thr_accel_pkg::word_t val;
    thr_accel_pkg::word_t prev;
    int                   mark;
    int                   fails;
    logic [9:0]           idx;
    // Pattern built from the full word address
    for (int i = 0; i < 1024; i++) begin
      idx    = i[9:0];
      mem[i] = {6'h2a, idx, 6'h15, idx};
    end

    mark = 0;
    while (rst_n !== 1'b1 && mark < 50) begin
      @(posedge clk);
      mark++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      $display("test failed");
      $finish;
    end
    @(posedge clk);

    mark = errors;
    read_reg(`THR_REG_READY, val);
    check_value("READY after reset", val, 32'd0);
    write_reg(`THR_REG_SRC, 32'h0000_1234);
    write_reg(`THR_REG_DST, 32'h0000_5678);
    write_reg(`THR_REG_THR, 32'hdead_beef);
    write_reg(`THR_REG_SIZE, 32'h0000_02a5);
    read_reg(`THR_REG_SRC, val);
    check_value("SRC", val, 32'h0000_1234);
    read_reg(`THR_REG_DST, val);
    check_value("DST", val, 32'h0000_5678);
    read_reg(`THR_REG_THR, val);
    check_value("THR", val, 32'hdead_beef);
    read_reg(`THR_REG_SIZE, val);
    check_value("SIZE", val, 32'h0000_02a5);
    write_reg(`THR_REG_READY, 32'd1);
    read_reg(`THR_REG_READY, val);
    check_value("READY", val, 32'd1);
    write_reg(`THR_REG_READY, 32'd0);
    read_reg(`THR_REG_READY, val);
    check_value("READY", val, 32'd0);
    report_case(1, "register readback", mark);

    mark = errors;
    start_job(32'h000, 32'h800, 32'h0, 16);
    wait_ready(400);
    check_job(32'h000, 32'h800, 32'h0, 16, 1'b1);
    read_reg(`THR_REG_READY, val);
    check_value("READY after job", val, 32'd1);
    report_case(2, "plain copy", mark);

    mark = errors;
    fill_random(32'h100, 24);
    start_job(32'h100, 32'hA00, 32'h8000_0000, 24);
    wait_ready(400);
    check_job(32'h100, 32'hA00, 32'h8000_0000, 24, 1'b1);
    report_case(3, "clipping", mark);

    // Mostly stalled grants on both channels
    mark = errors;
    grant_level = 1;
    fill_random(32'h200, 48);
    start_job(32'h200, 32'hC00, 32'h4000_0000, 48);
    wait_ready(2000);
    check_job(32'h200, 32'hC00, 32'h4000_0000, 48, 1'b1);
    grant_level = 3;
    report_case(4, "grant stalls", mark);

    mark = errors;
    read_reg(`THR_REG_READY, prev);
    write_reg(`THR_REG_SIZE, 32'd0);
    write_reg(`THR_REG_START, 32'd1);
    // Ready is read in every cycle because even an empty job would drop it briefly
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_write <= 1'b0;
    reg_addr  <= `THR_REG_READY;
    repeat (20) begin
      @(negedge clk);
      check_value("rd_req_o", 32'(rd_req), 32'd0);
      check_value("wr_req_o", 32'(wr_req), 32'd0);
      check_value("READY after empty start", reg_rdata, prev);
    end
    @(posedge clk);
    reg_valid <= 1'b0;
    report_case(5, "zero size start", mark);

    mark = errors;
    fill_random(32'h600, 20);
    start_job(32'h400, 32'hE00, 32'h0, 20);
    wait_ready(400);
    start_job(32'h600, 32'hF00, 32'h8000_0000, 20);
    wait_ready(400);
    check_job(32'h400, 32'hE00, 32'h0, 20, 1'b0);
    check_job(32'h600, 32'hF00, 32'h8000_0000, 20, 1'b1);
    report_case(6, "back-to-back jobs", mark);

    fails = errors + dut.u_assert.fail_cnt;
    $display("%0d cases, %0d checks, %0d mismatches, %0d assertion failures",
             ncases, checks, errors, dut.u_assert.fail_cnt);
    if (fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* testbench/thr_accel_assert.sv */
/* Interface rules of the threshold accelerator, checked on its top ports.
   Bound to thr_accel_top by the testbench; fail_cnt counts failed assertions. */
`timescale 1ns/1ps
`include "thr_accel_macros.svh"

module thr_accel_assert (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        reg_valid_i,
  input logic        reg_write_i,
  input logic [7:0]  reg_addr_i,
  input logic [31:0] reg_wdata_i,
  input logic        rd_req_i,
  input logic [31:0] rd_addr_i,
  input logic        rd_gnt_i,
  input logic        rd_rvalid_i,
  input logic        wr_req_i,
  input logic [31:0] wr_addr_i,
  input logic [31:0] wr_wdata_i,
  input logic        wr_gnt_i
);

  int unsigned fail_cnt = 0;
  logic        start_wr;
  logic        armed_q;
  logic        got_data_q;
  logic [3:0]  out_q;

  assign start_wr = reg_valid_i && reg_write_i && (reg_addr_i == `THR_REG_START)
                    && reg_wdata_i[0];

  // Software start seen, first read answer of the job seen, reads in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q    <= 1'b0;
      got_data_q <= 1'b0;
      out_q      <= '0;
    end else begin
      if (start_wr) armed_q <= 1'b1;
      if (start_wr) begin
        got_data_q <= 1'b0;
      end else if (rd_rvalid_i) begin
        got_data_q <= 1'b1;
      end
      out_q <= out_q + 4'(rd_req_i && rd_gnt_i) - 4'(rd_rvalid_i);
    end
  end

  no_req_without_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_req_i || wr_req_i) |-> armed_q)
    else begin $error("memory request raised without a start"); fail_cnt++; end

  no_write_before_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req_i |-> got_data_q)
    else begin $error("write request before the first read response"); fail_cnt++; end

  rd_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_req_i && !rd_gnt_i) |=> (rd_req_i && $stable(rd_addr_i)))
    else begin $error("read request dropped or changed while waiting"); fail_cnt++; end

  wr_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_req_i && !wr_gnt_i) |=> (wr_req_i && $stable(wr_addr_i) && $stable(wr_wdata_i)))
    else begin $error("write request dropped or changed while waiting"); fail_cnt++; end

  rd_addr_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_req_i && rd_gnt_i) |=> (rd_addr_i == $past(rd_addr_i) + 32'd4))
    else begin $error("read address did not advance by 4"); fail_cnt++; end

  wr_addr_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_req_i && wr_gnt_i) |=> (wr_addr_i == $past(wr_addr_i) + 32'd4))
    else begin $error("write address did not advance by 4"); fail_cnt++; end

  out_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_q <= 4'(`THR_FIFO_DEPTH))
    else begin $error("outstanding reads exceed the FIFO depth"); fail_cnt++; end

endmodule

/* thr_accel_top.f */
+incdir+rtl
rtl/thr_accel_pkg.sv
rtl/thr_cfg_if.sv
rtl/thr_stream_if.sv
rtl/thr_accel_fifo.sv
rtl/thr_accel_regs.sv
rtl/thr_accel_engine.sv
rtl/thr_accel_result.sv
rtl/thr_accel_top.sv
testbench/tb_clock_gen.sv
testbench/thr_accel_assert.sv
testbench/tb_thr_accel.sv
